// File: vlog.f
src/bridge_pkg.sv
src/inst_store.sv
src/data_store.sv
src/request_router.sv
src/cpu_mem_bridge.sv
verification/clock_gen.sv
verification/bridge_sva.sv
verification/tb_cpu_mem_bridge.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the result from the log.

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

rm -rf obj_dir

verilator --binary --assert -j 0 \
	-f vlog.f \
	--top-module tb_cpu_mem_bridge \
	-o tb_cpu_mem_bridge \
	> "$build_log" 2>&1 \
	|| { echo "Build failed, see $build_log"; exit 1; }

# A raised error limit lets assertion failures be counted to the end of the run.
./obj_dir/tb_cpu_mem_bridge +verilator+error+limit+1000 > "$sim_log" 2>&1
cat "$sim_log"

grep -q "Simulation completed successfully" "$sim_log" \
	&& { echo "RESULT: PASS"; exit 0; } \
	|| { echo "RESULT: FAIL, see $sim_log"; exit 1; }

// File: verification/tb_cpu_mem_bridge.sv
`default_nettype none

module tb_cpu_mem_bridge;

	timeunit 1ns;
	timeprecision 100ps;

	logic                              clk_cpu;
	logic                              rst;
	logic                              run;
	logic                              boot_write;
	logic [bridge_pkg::index_bits-1:0] boot_index;
	logic [31:0]                       boot_data;
	logic [31:0]                       rw_address;
	logic                              read_request;
	logic                              write_request;
	logic [31:0]                       write_data;
	logic [3:0]                        write_strobe;
	wire  [31:0]                       read_data;
	wire                               read_response;
	wire                               write_response;
	wire                               fault;

	bridge_pkg::mem_word_u inst_model [bridge_pkg::inst_words];
	bridge_pkg::mem_word_u data_model [bridge_pkg::data_words];

	logic [7:0] booted_idx [16];
	logic [7:0] burst_idx [16];

	int    seed          = 32'h5cba7ab0;
	int    resp_timeout  = 8;
	int    quiet_cycles  = 6;
	int    reset_timeout = 20;
	int    test_errs     = 0;
	int    pass_count    = 0;
	int    fail_count    = 0;
	int    sva_fails;
	string cur_test;

	clock_gen clock_gen_inst (
		.clk_cpu (clk_cpu),
		.rst     (rst)
	);

	cpu_mem_bridge cpu_mem_bridge_inst (
		.clk_cpu        (clk_cpu),
		.rst            (rst),
		.run            (run),
		.boot_write     (boot_write),
		.boot_index     (boot_index),
		.boot_data      (boot_data),
		.rw_address     (rw_address),
		.read_request   (read_request),
		.write_request  (write_request),
		.write_data     (write_data),
		.write_strobe   (write_strobe),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.fault          (fault)
	);

	function automatic logic [31:0] inst_addr(input logic [7:0] idx);
		return {22'd0, idx, 2'b00};
	endfunction

	function automatic logic [31:0] data_addr(input logic [7:0] idx);
		return bridge_pkg::data_base | {22'd0, idx, 2'b00};
	endfunction

	// Strobed bytes come from the new word, the rest stay.
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] strb);
		bridge_pkg::mem_word_u o;
		bridge_pkg::mem_word_u n;
		o.word = old_w;
		n.word = new_w;
		for (int b = 0; b < 4; b++) begin
			if (strb[b]) begin
				o.bytes[b] = n.bytes[b];
			end
		end
		return o.word;
	endfunction

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		if (test_errs == 0) begin
			$display("PASS  %s", cur_test);
			pass_count++;
		end else begin
			$display("FAIL  %s (%0d errors)", cur_test, test_errs);
			fail_count++;
		end
	endtask

	task automatic set_run(input logic value);
		@(posedge clk_cpu);
		run <= value;
	endtask

	task automatic boot_word(input logic [7:0] idx, input logic [31:0] w);
		@(posedge clk_cpu);
		boot_write <= 1'b1;
		boot_index <= idx;
		boot_data  <= w;
		@(posedge clk_cpu);
		boot_write <= 1'b0;
	endtask

	task automatic drive_req(input logic rd, input logic wr, input logic [31:0] addr,
			input logic [31:0] wdata, input logic [3:0] strb);
		@(posedge clk_cpu);
		read_request  <= rd;
		write_request <= wr;
		rw_address    <= addr;
		write_data    <= wdata;
		write_strobe  <= strb;
	endtask

	task automatic go_idle();
		drive_req(1'b0, 1'b0, 32'h0, 32'h0, 4'h0);
	endtask

	// Response to the request taken at the last rising edge.
	task automatic collect(input logic [31:0] addr, input logic is_read,
			input logic [31:0] exp_data, input logic exp_fault);
		int cnt;
		cnt = 0;
		@(negedge clk_cpu);
		while (!read_response && !write_response && cnt < resp_timeout) begin
			@(negedge clk_cpu);
			cnt++;
		end
		if (!read_response && !write_response) begin
			$display("%s: no response for address %h within %0d cycles",
				cur_test, addr, resp_timeout);
			test_errs++;
		end else begin
			assert (read_response == is_read) else begin
				$display("** Error %s: read_response at %h expected %b, actual %b",
					cur_test, addr, is_read, read_response);
				test_errs++;
			end
			assert (fault == exp_fault) else begin
				$display("** Error %s: fault at %h expected %b, actual %b",
					cur_test, addr, exp_fault, fault);
				test_errs++;
			end
			if (is_read) begin
				assert (read_data == exp_data) else begin
					$display("** Error %s: read_data at %h expected %h, actual %h",
						cur_test, addr, exp_data, read_data);
					test_errs++;
				end
			end
		end
	endtask

	task automatic read_word(input logic [31:0] addr, input logic [31:0] exp_data,
			input logic exp_fault);
		drive_req(1'b1, 1'b0, addr, 32'h0, 4'h0);
		go_idle();
		collect(addr, 1'b1, exp_data, exp_fault);
	endtask

	task automatic write_word(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, input logic exp_fault);
		drive_req(1'b0, 1'b1, addr, wdata, strb);
		go_idle();
		collect(addr, 1'b0, 32'h0, exp_fault);
	endtask

	task automatic expect_silence(input logic [31:0] addr);
		for (int cnt = 0; cnt < quiet_cycles; cnt++) begin
			@(negedge clk_cpu);
			assert (!read_response && !write_response) else begin
				$display("%s: response for address %h while run was low", cur_test, addr);
				test_errs++;
			end
		end
	endtask

	// One request per cycle, each answered while the next is taken.
	task automatic data_burst(input logic is_write);
		logic [31:0] w;
		for (int i = 0; i <= 16; i++) begin
			if (i == 16) begin
				go_idle();
			end else if (is_write) begin
				w = $random(seed);
				data_model[burst_idx[i]].word = w;
				drive_req(1'b0, 1'b1, data_addr(burst_idx[i]), w, 4'hF);
			end else begin
				drive_req(1'b1, 1'b0, data_addr(burst_idx[i]), 32'h0, 4'h0);
			end
			if (i > 0) begin
				collect(data_addr(burst_idx[i-1]), ~is_write,
					data_model[burst_idx[i-1]].word, 1'b0);
			end
		end
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] w;
		logic [7:0]  idx;
		int          cnt;

		run           = 1'b0;
		boot_write    = 1'b0;
		boot_index    = '0;
		boot_data     = 32'h0;
		rw_address    = 32'h0;
		read_request  = 1'b0;
		write_request = 1'b0;
		write_data    = 32'h0;
		write_strobe  = 4'h0;

		start_test("reset");
		cnt = 0;
		@(posedge clk_cpu);
		while (rst && cnt < reset_timeout) begin
			@(posedge clk_cpu);
			cnt++;
		end
		if (rst) begin
			$display("reset: rst still high after %0d cycles", reset_timeout);
			test_errs++;
		end
		@(negedge clk_cpu);
		assert (read_data == 32'h0) else begin
			$display("** Error reset: read_data expected %h, actual %h", 32'h0, read_data);
			test_errs++;
		end
		finish_test();

		start_test("boot_fetch");
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			w = $random(seed);
			booted_idx[i] = r[7:0];
			inst_model[r[7:0]].word = w;
			boot_word(r[7:0], w);
		end
		set_run(1'b1);
		for (int i = 0; i < 16; i++) begin
			read_word(inst_addr(booted_idx[i]), inst_model[booted_idx[i]].word, 1'b0);
		end
		finish_test();

		start_test("full_word");
		for (int i = 0; i < 16; i++) begin
			r = $random(seed);
			burst_idx[i] = r[7:0];
		end
		data_burst(1'b1);
		data_burst(1'b0);
		finish_test();

		start_test("strobe_merge");
		for (int s = 0; s < 16; s++) begin
			idx = 8'h40 + s[7:0];
			r = $random(seed);
			w = $random(seed);
			write_word(data_addr(idx), r, 4'hF, 1'b0);
			write_word(data_addr(idx), w, s[3:0], 1'b0);
			data_model[idx].word = merge_bytes(r, w, s[3:0]);
			read_word(data_addr(idx), data_model[idx].word, 1'b0);
		end
		finish_test();

		start_test("fault");
		idx = booted_idx[0];
		write_word(inst_addr(idx), ~inst_model[idx].word, 4'hF, 1'b1);
		read_word(inst_addr(idx), inst_model[idx].word, 1'b0);
		read_word(bridge_pkg::data_end + 32'd4, 32'h0, 1'b1);
		read_word(32'hFFFF_FFFC, 32'h0, 1'b1);
		w = $random(seed);
		data_model[0].word = w;
		write_word(bridge_pkg::data_base, w, 4'hF, 1'b0);
		write_word(32'h0000_1000, ~w, 4'hF, 1'b1); // Same index bits as data word 0.
		read_word(bridge_pkg::data_base, data_model[0].word, 1'b0);
		finish_test();

		start_test("run_gating");
		idx = booted_idx[1];
		set_run(1'b0);
		drive_req(1'b1, 1'b0, inst_addr(idx), 32'h0, 4'h0);
		go_idle();
		expect_silence(inst_addr(idx));
		drive_req(1'b0, 1'b1, bridge_pkg::data_base, ~data_model[0].word, 4'hF);
		go_idle();
		expect_silence(bridge_pkg::data_base);
		set_run(1'b1);
		boot_word(idx, ~inst_model[idx].word);
		read_word(inst_addr(idx), inst_model[idx].word, 1'b0);
		read_word(bridge_pkg::data_base, data_model[0].word, 1'b0);
		finish_test();

		sva_fails = cpu_mem_bridge_inst.sva_inst.fail_count;
		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			pass_count, fail_count, sva_fails);
		if (fail_count == 0 && sva_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/bridge_sva.sv
`default_nettype none

module bridge_sva (
	input wire clk_cpu,
	input wire rst,
	input wire run,
	input wire read_request,
	input wire write_request,
	input wire read_response,
	input wire write_response,
	input wire fault
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned miss_fails    = 0;
	int unsigned orphan_fails  = 0;
	int unsigned overlap_fails = 0;
	int unsigned reset_fails   = 0;
	int unsigned fail_count;

	assign fail_count = miss_fails + orphan_fails + overlap_fails + reset_fails;

	// Accepted request gets the matching response exactly one cycle later.
	answered: assert property (@(posedge clk_cpu) disable iff (rst)
		(run && (read_request || write_request)) |=>
			((read_response == $past(read_request)) &&
			 (write_response == $past(write_request))))
		else begin
			miss_fails++;
			$error("request was not answered by its response one cycle later");
		end

	no_orphan: assert property (@(posedge clk_cpu) disable iff (rst)
		(read_response || write_response || fault) |->
			$past(run && (read_request || write_request)))
		else begin
			orphan_fails++;
			$error("response or fault without a request in the previous cycle");
		end

	one_kind: assert property (@(posedge clk_cpu) disable iff (rst)
		!(read_response && write_response))
		else begin
			overlap_fails++;
			$error("read and write responses high in the same cycle");
		end

	// Responses are quiet right after a reset cycle.
	reset_quiet: assert property (@(posedge clk_cpu)
		rst |=> (!read_response && !write_response && !fault))
		else begin
			reset_fails++;
			$error("response or fault high in the cycle after reset");
		end

endmodule

bind cpu_mem_bridge bridge_sva sva_inst (
	.clk_cpu        (clk_cpu),
	.rst            (rst),
	.run            (run),
	.read_request   (read_request),
	.write_request  (write_request),
	.read_response  (read_response),
	.write_response (write_response),
	.fault          (fault)
);

`default_nettype wire

// File: verification/clock_gen.sv
`default_nettype none

module clock_gen (
	output logic clk_cpu,
	output logic rst
);

	timeunit 1ns;
	timeprecision 100ps;

	always #20 clk_cpu = ~clk_cpu; // 40 ns period.

	initial begin
		clk_cpu = 1'b0;
		rst     = 1'b1;
		repeat (4) @(posedge clk_cpu);
		rst <= 1'b0; // Released after the fourth rising edge.
	end

endmodule

`default_nettype wire

// File: src/cpu_mem_bridge.sv
`default_nettype none

module cpu_mem_bridge (
	input  wire                               clk_cpu,
	input  wire                               rst,
	input  wire                               run,
	input  wire                               boot_write,
	input  wire  [bridge_pkg::index_bits-1:0] boot_index,
	input  wire  [31:0]                       boot_data,
	input  wire  [31:0]                       rw_address,
	input  wire                               read_request,
	input  wire                               write_request,
	input  wire  [31:0]                       write_data,
	input  wire  [3:0]                        write_strobe,
	output logic [31:0]                       read_data,
	output logic                              read_response,
	output logic                              write_response,
	output logic                              fault
);

	wire                              inst_read;
	wire [bridge_pkg::index_bits-1:0] inst_index;
	wire [31:0]                       inst_rdata;

	wire                              data_read;
	wire                              data_write;
	wire [bridge_pkg::index_bits-1:0] data_index;
	wire [31:0]                       data_wdata;
	wire [3:0]                        data_strobe;
	wire [31:0]                       data_rdata;

	request_router router_inst (
		.clk_cpu        (clk_cpu),
		.rst            (rst),
		.run            (run),
		.rw_address     (rw_address),
		.read_request   (read_request),
		.write_request  (write_request),
		.write_data     (write_data),
		.write_strobe   (write_strobe),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.fault          (fault),
		.inst_read      (inst_read),
		.inst_index     (inst_index),
		.data_read      (data_read),
		.data_write     (data_write),
		.data_index     (data_index),
		.data_wdata     (data_wdata),
		.data_strobe    (data_strobe),
		.inst_rdata     (inst_rdata),
		.data_rdata     (data_rdata)
	);

	// Program words, preloaded through the boot port.
	inst_store inst_store_inst (
		.clk_cpu    (clk_cpu),
		.rst        (rst),
		.run        (run),
		.boot_write (boot_write),
		.boot_index (boot_index),
		.boot_data  (boot_data),
		.inst_read  (inst_read),
		.inst_index (inst_index),
		.inst_rdata (inst_rdata)
	);

	data_store data_store_inst (
		.clk_cpu     (clk_cpu),
		.rst         (rst),
		.data_read   (data_read),
		.data_write  (data_write),
		.data_index  (data_index),
		.data_wdata  (data_wdata),
		.data_strobe (data_strobe),
		.data_rdata  (data_rdata)
	);

endmodule

`default_nettype wire

// File: src/request_router.sv
`default_nettype none

module request_router (
	input  wire                               clk_cpu,
	input  wire                               rst,
	input  wire                               run,
	input  wire  [31:0]                       rw_address,
	input  wire                               read_request,
	input  wire                               write_request,
	input  wire  [31:0]                       write_data,
	input  wire  [3:0]                        write_strobe,
	output logic [31:0]                       read_data,
	output logic                              read_response,
	output logic                              write_response,
	output logic                              fault,
	output logic                              inst_read,
	output logic [bridge_pkg::index_bits-1:0] inst_index,
	output logic                              data_read,
	output logic                              data_write,
	output logic [bridge_pkg::index_bits-1:0] data_index,
	output logic [31:0]                       data_wdata,
	output logic [3:0]                        data_strobe,
	input  wire  [31:0]                       inst_rdata,
	input  wire  [31:0]                       data_rdata
);

	logic in_inst;
	logic in_data;
	logic rd_req;
	logic wr_req;
	logic bad_req;

	logic rd_q;
	logic wr_q;
	logic inst_q;
	logic data_q;
	logic fault_q;

	bridge_pkg::mem_word_u rdata_sel;

	// Region decode, done once per request.
	assign in_inst = (rw_address <= bridge_pkg::end_inst);
	assign in_data = (rw_address >= bridge_pkg::data_base) &&
	                 (rw_address <= bridge_pkg::data_end);

	// Nothing is accepted while the core is held off.
	assign rd_req = run & read_request;
	assign wr_req = run & write_request;

	// Instruction side is read only; gaps and the range above data_end fault.
	assign bad_req = (wr_req & ~in_data) | (rd_req & ~in_inst & ~in_data);

	// At most one store is enabled per cycle.
	assign inst_read  = rd_req & in_inst;
	assign data_read  = rd_req & in_data;
	assign data_write = wr_req & in_data;

	assign inst_index  = rw_address[9:2];
	assign data_index  = rw_address[9:2];
	assign data_wdata  = write_data;
	assign data_strobe = write_strobe;

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			rd_q    <= 1'b0;
			wr_q    <= 1'b0;
			inst_q  <= 1'b0;
			data_q  <= 1'b0;
			fault_q <= 1'b0;
		end else begin
			rd_q    <= rd_req;
			wr_q    <= wr_req;
			inst_q  <= inst_read;
			data_q  <= data_read;
			fault_q <= bad_req;
		end
	end

	assign read_response  = rd_q;
	assign write_response = wr_q;
	assign fault          = fault_q;

	// Return the word of whichever store was read, zero on a faulting read.
	always_comb begin
		if (inst_q) begin
			rdata_sel.word = inst_rdata;
		end else if (data_q) begin
			rdata_sel.word = data_rdata;
		end else begin
			rdata_sel.word = '0;
		end
	end

	assign read_data = rdata_sel.word;

endmodule

`default_nettype wire

// File: src/data_store.sv
`default_nettype none

module data_store (
	input  wire                              clk_cpu,
	input  wire                              rst,
	input  wire                              data_read,
	input  wire                              data_write,
	input  wire [bridge_pkg::index_bits-1:0] data_index,
	input  wire [31:0]                       data_wdata,
	input  wire [3:0]                        data_strobe,
	output logic [31:0]                      data_rdata
);

	bridge_pkg::mem_word_u mem [bridge_pkg::data_words];

	bridge_pkg::mem_word_u old_word;
	bridge_pkg::mem_word_u wdata_u;
	bridge_pkg::mem_word_u merged;

	// Byte merge of the incoming word over the stored one.
	always_comb begin
		old_word = mem[data_index];
		wdata_u.word = data_wdata;
		merged = old_word;
		for (int i = 0; i < 4; i++) begin
			if (data_strobe[i]) begin
				merged.bytes[i] = wdata_u.bytes[i]; // Strobed lane takes new byte.
			end
		end
	end

	// Read and merge happen in the same cycle, so the write lands at this edge.
	always_ff @(posedge clk_cpu) begin
		if (data_write) begin
			mem[data_index] <= merged;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			data_rdata <= '0;
		end else if (data_read) begin
			data_rdata <= mem[data_index].word; // Valid at the next edge.
		end
	end

endmodule

`default_nettype wire

// File: src/inst_store.sv
`default_nettype none

module inst_store (
	input  wire                              clk_cpu,
	input  wire                              rst,
	input  wire                              run,
	input  wire                              boot_write,
	input  wire [bridge_pkg::index_bits-1:0] boot_index,
	input  wire [31:0]                       boot_data,
	input  wire                              inst_read,
	input  wire [bridge_pkg::index_bits-1:0] inst_index,
	output logic [31:0]                      inst_rdata
);

	logic [31:0] mem [bridge_pkg::inst_words];
	logic        boot_en;

	// Boot loader owns the store only while the core is held off.
	assign boot_en = boot_write & ~run;

	always_ff @(posedge clk_cpu) begin
		if (boot_en) begin
			mem[boot_index] <= boot_data;
		end
	end

	// Registered fetch, valid one cycle after inst_read.
	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			inst_rdata <= '0;
		end else if (inst_read) begin
			inst_rdata <= mem[inst_index];
		end
	end

endmodule

`default_nettype wire

// File: src/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

	// Store depths in 32-bit words.
	localparam int inst_words = 256;
	localparam int data_words = 256;

	// Word index taken from address bits 9:2.
	localparam int index_bits = 8;

	// Byte address map.
	localparam logic [31:0] end_inst  = 32'h0000_03FC; // Last instruction word.
	localparam logic [31:0] data_base = 32'h0000_0400; // First data word.
	localparam logic [31:0] data_end  = 32'h0000_07FC; // Last data word.

	// A stored word, seen whole or as four bytes.
	// bytes[0] is the least significant byte, matching write_strobe[0].
	typedef union packed {
		logic [31:0]      word;
		logic [3:0][7:0]  bytes;
	} mem_word_u;

endpackage

`default_nettype wire
